//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 20
) (
    output logic clk
);
    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;   // Free running, starts low
endmodule

`default_nettype wire

//--- bench/tb_cpu.sv
`default_nettype none

module tb_cpu;
    import isa_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int N_RANDOM  = 40;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] mem [MEM_WORDS];    // Memory seen by the DUT
    logic [31:0] mmem [MEM_WORDS];   // Copy used by the ISA model
    logic [31:0] exp_adr [$];
    logic [31:0] exp_dat [$];
    logic [3:0]  exp_sel [$];

    integer      seed = 75553;
    int          errors = 0;
    int          tests = 0;
    int          failed = 0;
    int          n_prog = 0;
    int          wait_left = 0;
    int          halt_hits = 0;
    int          stores_seen = 0;
    int          cycles;
    int          err_start;
    bit          pending = 0;
    bit          first_seen = 0;
    bit          cyc_in_reset = 0;
    logic [31:0] first_adr;
    logic        first_we;
    logic [31:0] halt_pc;

    tb_clock #(.PERIOD(20)) i_clock (.clk);

    cpu_top #(.RESET_PC(32'h0)) i_cpu_top (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] a;
        a = idx * 4;
        return (a * 32'h9e3779b1) ^ 32'h3c5a_0f17;   // Depends on every address bit
    endfunction

    function automatic logic [31:0] lane_mask(input logic [3:0] sel);
        return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[n_prog] = w;
        n_prog++;
    endtask

    task automatic emit_r(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
        emit({OP_RTYPE, rs, rt, rd, 5'd0, fn});
    endtask

    task automatic emit_i(input logic [5:0] opc, input logic [4:0] rs, rt,
                          input logic [15:0] imm);
        emit({opc, rs, rt, imm});
    endtask

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] off;
        int          kind;
        for (int r = 1; r < 32; r++) begin             // Register init
            emit_i(OP_LUI, 5'd0, r[4:0], 16'($random(seed)));
            emit_i(OP_ORI, r[4:0], r[4:0], 16'($random(seed)));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            rd   = 5'd1 + 5'({$random(seed)} % 31);
            rs   = 5'({$random(seed)} % 32);
            rt   = 5'({$random(seed)} % 32);
            off  = 16'h0400 + 16'(({$random(seed)} % 64) * 4);   // Data region
            kind = {$random(seed)} % 12;
            case (kind)
                0:  emit_r(rs, rt, rd, FN_ADD);
                1:  emit_r(rs, rt, rd, FN_SUB);
                2:  emit_r(rs, rt, rd, FN_AND);
                3:  emit_r(rs, rt, rd, FN_OR);
                4:  emit_r(rs, rt, rd, FN_SLT);
                5:  emit_r(rs, rt, rd, FN_MUL);
                6:  emit_i(OP_ADDI, rs, rd, 16'($random(seed)));
                7:  emit_i(OP_ORI, rs, rd, 16'($random(seed)));
                8:  emit_i(OP_LUI, 5'd0, rd, 16'($random(seed)));
                9:  emit_i(OP_LDW, 5'd0, rd, off);
                10: emit_i(OP_STW, 5'd0, rt, off);
                default: emit_i(OP_STB, 5'd0, rt, off + 16'({$random(seed)} % 4));
            endcase
        end
        emit_i(OP_STB, 5'd0, 5'd5, 16'h0441);           // Two lanes then a merged read
        emit_i(OP_STB, 5'd0, 5'd6, 16'h0443);
        emit_i(OP_LDW, 5'd0, 5'd7, 16'h0440);
        emit_r(5'd9, 5'd10, 5'd11, FN_MUL);             // Product wider than one word
        emit_i(OP_BEQ, 5'd0, 5'd0, 16'd2);              // Taken so the next two are skipped
        emit_i(OP_ADDI, 5'd1, 5'd1, 16'd1);
        emit_i(OP_ADDI, 5'd2, 5'd2, 16'd1);
        emit_i(OP_ORI, 5'd0, 5'd29, 16'd1);
        emit_i(OP_BEQ, 5'd0, 5'd29, 16'd2);             // Not taken
        emit_i(OP_ADDI, 5'd3, 5'd3, 16'd5);
        emit({OP_J, 26'(n_prog + 3)});                  // Forward jump over two
        emit_i(OP_ADDI, 5'd4, 5'd4, 16'd7);
        emit_i(OP_ADDI, 5'd8, 5'd8, 16'd7);
        for (int r = 1; r < 32; r++)                    // Register dump
            emit_i(OP_STW, 5'd0, r[4:0], 16'h0800 + 16'(r * 4));
        halt_pc = n_prog * 4;
        emit({OP_J, 26'(n_prog)});                      // Jump to self
    endtask

    // Reference ISA model run up to the jump to self
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] res;
        logic [31:0] ea;
        logic [3:0]  sel;
        logic [4:0]  wd;
        bit          wr;
        for (int r = 0; r < 32; r++) regs[r] = 32'd0;
        pc = 32'd0;
        for (int step = 0; step < 10000; step++) begin
            ins  = mmem[pc[11:2]];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            ea   = a + simm;
            wd   = ins[20:16];
            wr   = 1'b1;
            res  = 32'd0;
            case (ins[31:26])
                OP_RTYPE: begin
                    wd = ins[15:11];
                    case (ins[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_MUL:  res = a * b;           // Low word
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = ea;
                OP_ORI:  res = a | {16'h0, ins[15:0]};
                OP_LUI:  res = {ins[15:0], 16'h0};
                OP_LDW:  res = mmem[ea[11:2]];
                OP_STW, OP_STB: begin
                    wr  = 1'b0;
                    sel = (ins[31:26] == OP_STB) ? 4'b0001 << ea[1:0] : 4'hf;
                    res = (ins[31:26] == OP_STB) ? {4{b[7:0]}} : b;
                    mmem[ea[11:2]] = (mmem[ea[11:2]] & ~lane_mask(sel)) |
                                     (res & lane_mask(sel));
                    exp_adr.push_back({ea[31:2], 2'b00});
                    exp_dat.push_back(res);
                    exp_sel.push_back(sel);
                end
                default: wr = 1'b0;                     // BEQ and J
            endcase
            if (wr && wd != 5'd0) regs[wd] = res;
            if (ins[31:26] == OP_J) begin
                res = {pc[31:28], ins[25:0], 2'b00};
                if (res == pc) return;
                pc = res;
            end else if (ins[31:26] == OP_BEQ && a == b) begin
                pc = pc + 32'd4 + (simm << 2);
            end else begin
                pc = pc + 32'd4;
            end
        end
        $display("ISA model did not reach the halt loop");
        errors++;
    endtask

    task automatic note_store();
        if (exp_adr.size() == 0) begin
            $display("Unexpected store to address %h after the last expected store", wb_adr);
            errors++;
        end else begin
            check_value("wb_adr", wb_adr, exp_adr[0]);
            check_value("wb_sel", {28'd0, wb_sel}, {28'd0, exp_sel[0]});
            check_value("wb_dat_w", wb_dat_w & lane_mask(wb_sel),
                        exp_dat[0] & lane_mask(exp_sel[0]));
            void'(exp_adr.pop_front());
            void'(exp_dat.pop_front());
            void'(exp_sel.pop_front());
        end
        stores_seen++;
    endtask

    // Memory slave with 0 to 3 wait states per transfer
    always @(negedge clk) begin
        check_value("wb_stb", {31'd0, wb_stb}, {31'd0, wb_cyc});   // Strobe moves with cyc
        if (!rst_n) begin
            wb_ack = 1'b0;
            if (wb_cyc) cyc_in_reset = 1'b1;
        end else if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!pending) begin
                pending   = 1'b1;
                wait_left = {$random(seed)} % 4;
                if (!first_seen) begin
                    first_seen = 1'b1;
                    first_adr  = wb_adr;
                    first_we   = wb_we;
                end
            end
            if (wait_left == 0) begin
                pending = 1'b0;
                wb_ack  = 1'b1;
                if (wb_we) begin
                    note_store();
                    mem[wb_adr[11:2]] = (mem[wb_adr[11:2]] & ~lane_mask(wb_sel)) |
                                        (wb_dat_w & lane_mask(wb_sel));
                end else begin
                    wb_dat_r = mem[wb_adr[11:2]];
                    if (wb_adr == halt_pc) halt_hits++;
                end
            end else begin
                wait_left--;
            end
        end
    end

    task automatic end_test(input string name);
        tests++;
        if (errors == err_start) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: failed", name);
            failed++;
        end
        err_start = errors;
    endtask

    initial begin
        rst_n    = 1'b0;
        wb_ack   = 1'b0;
        wb_dat_r = 32'd0;
        for (int i = 0; i < MEM_WORDS; i++) mem[i] = fill_word(i);
        build_program();
        for (int i = 0; i < MEM_WORDS; i++) mmem[i] = mem[i];
        run_model();
        err_start = errors;
        $display("Program of %0d words, %0d stores expected", n_prog, exp_adr.size());

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        cycles = 0;
        while (!first_seen && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (!first_seen) begin
            $display("No bus request within 100 cycles of reset release");
            errors++;
        end
        if (cyc_in_reset) begin
            $display("wb_cyc went high during reset");
            errors++;
        end
        check_value("first wb_adr", first_adr, 32'h0);
        check_value("first wb_we", {31'd0, first_we}, 32'h0);
        end_test("reset_and_first_fetch");

        cycles = 0;
        while (halt_hits < 4 && cycles < 200000) begin
            @(posedge clk);
            cycles++;
        end
        if (halt_hits < 4) begin
            $display("Timeout waiting for the halt loop");
            errors++;
        end
        end_test("halt_loop_reached");

        repeat (40) @(posedge clk);                     // Catch stray late stores
        if (exp_adr.size() != 0) begin
            $display("%0d expected stores never appeared", exp_adr.size());
            errors++;
        end
        end_test("store_stream");

        $display("Tests: %0d, failed: %0d, stores: %0d, errors: %0d",
                 tests, failed, stores_seen, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/bus_pkg.sv
rtl/isa_pkg.sv
rtl/wb_if.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/wb_arbiter.sv
rtl/cpu_top.sv
bench/tb_clock.sv
bench/tb_cpu.sv

//--- rtl/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Wishbone port widths, byte granular select
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    // Arbiter master indices, data side has priority
    localparam logic M_DATA  = 1'b0;
    localparam logic M_FETCH = 1'b1;

endpackage

`default_nettype wire

//--- rtl/cpu_top.sv
`default_nettype none

module cpu_top #(
    parameter logic [bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    output logic                       wb_cyc,
    output logic                       wb_stb,
    output logic                       wb_we,
    output logic [bus_pkg::ADDR_W-1:0] wb_adr,
    output logic [bus_pkg::DATA_W-1:0] wb_dat_w,
    output logic [bus_pkg::SEL_W-1:0]  wb_sel,
    input  wire [bus_pkg::DATA_W-1:0]  wb_dat_r,
    input  wire                        wb_ack
);
    import isa_pkg::*;
    import bus_pkg::*;

    wb_if    fetch_bus ();
    wb_if    data_bus ();
    instr_if fetch_q ();        // Prefetch buffer to decode

    logic              op_valid;
    logic              op_ready;
    dec_op_t           op;
    logic [4:0]        rd_addr_a;
    logic [4:0]        rd_addr_b;
    logic [31:0]       rd_data_a;
    logic [31:0]       rd_data_b;
    logic              wr_en;
    logic [4:0]        wr_addr;
    logic [31:0]       wr_data;
    logic              redirect;
    logic [ADDR_W-1:0] redirect_pc;

    fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
        .clk, .rst_n, .bus(fetch_bus), .out(fetch_q), .redirect, .redirect_pc
    );

    decode_stage i_decode (
        .clk, .rst_n, .in(fetch_q), .flush(redirect), .op_valid, .op_ready, .op
    );

    reg_file i_regs (
        .clk, .rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b, .wr_en, .wr_addr, .wr_data
    );

    exec_unit i_exec (
        .clk, .rst_n, .op_valid, .op_ready, .op, .rd_addr_a, .rd_addr_b,
        .rd_data_a, .rd_data_b, .wr_en, .wr_addr, .wr_data, .bus(data_bus),
        .redirect, .redirect_pc
    );

    wb_arbiter i_arb (
        .clk, .rst_n, .data_bus, .fetch_bus, .wb_cyc, .wb_stb, .wb_we,
        .wb_adr, .wb_dat_w, .wb_sel, .wb_dat_r, .wb_ack
    );

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`default_nettype none

module decode_stage (
    input  wire              clk,
    input  wire              rst_n,
    instr_if.sink            in,
    input  wire              flush,
    output logic             op_valid,
    input  wire              op_ready,
    output isa_pkg::dec_op_t op
);
    import isa_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;
    logic        load;
    dec_op_t     dec;

    assign opcode = in.instr[31:26];
    assign funct  = in.instr[5:0];
    assign imm16  = in.instr[15:0];

    assign in.ready = !op_valid || op_ready;   // Empty, or emptying this cycle
    assign load     = in.valid && in.ready && !flush;

    always_comb begin
        dec             = '0;
        dec.pc          = in.pc;
        dec.rs          = in.instr[25:21];
        dec.rt          = in.instr[20:16];
        dec.dest        = in.instr[20:16];     // rt target unless R-type
        dec.jump_target = {in.pc[31:28], in.instr[25:0], 2'b00};
        dec.alu_op      = ALU_ADD;
        // ORI zero extends, every other form sign extends
        if (opcode == OP_ORI) dec.imm = {16'h0000, imm16};
        else                  dec.imm = {{16{imm16[15]}}, imm16};
        case (opcode)
            OP_RTYPE: begin
                dec.dest      = in.instr[15:11];
                dec.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  dec.alu_op = ALU_ADD;
                    FN_SUB:  dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_MUL:  dec.alu_op = ALU_MUL;   // Low word only
                    default: dec.reg_write = 1'b0;   // Unknown function runs as a nop
                endcase
            end
            OP_ADDI: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_ORI: begin
                dec.alu_op    = ALU_OR;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_LUI: begin
                dec.alu_op    = ALU_LUI;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OP_LDW: begin
                dec.use_imm   = 1'b1;                // Address is rs + imm
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
            end
            OP_STW: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
            end
            OP_STB: begin
                dec.use_imm    = 1'b1;
                dec.mem_write  = 1'b1;
                dec.byte_store = 1'b1;
            end
            OP_BEQ: begin
                dec.alu_op    = ALU_SUB;
                dec.is_branch = 1'b1;
            end
            OP_J:    dec.is_jump = 1'b1;
            default: ;                               // Unknown opcode is a nop
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)        op_valid <= 1'b0;
        else if (flush)    op_valid <= 1'b0;   // Taken branch or jump in execute
        else if (load)     op_valid <= 1'b1;
        else if (op_ready) op_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (load) op <= dec;
    end

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`default_nettype none

module exec_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        op_valid,
    output logic                       op_ready,
    input  wire isa_pkg::dec_op_t      op,
    output logic [4:0]                 rd_addr_a,
    output logic [4:0]                 rd_addr_b,
    input  wire [31:0]                 rd_data_a,
    input  wire [31:0]                 rd_data_b,
    output logic                       wr_en,
    output logic [4:0]                 wr_addr,
    output logic [31:0]                wr_data,
    wb_if.master                       bus,
    output logic                       redirect,
    output logic [bus_pkg::ADDR_W-1:0] redirect_pc
);
    import isa_pkg::*;
    import bus_pkg::*;

    logic              accept;
    logic              is_mem;
    logic [31:0]       opnd_b;
    logic [31:0]       alu_res;
    logic [SEL_W-1:0]  st_sel;
    logic [DATA_W-1:0] st_dat;
    logic              mem_busy;    // Load or store cycle open
    logic              mem_done;    // Retire slot after ack
    logic              ld_wb;
    logic [4:0]        ld_dest;
    logic [DATA_W-1:0] ld_data;
    logic [ADDR_W-1:0] m_adr;
    logic [DATA_W-1:0] m_dat;
    logic [SEL_W-1:0]  m_sel;
    logic              m_we;

    assign op_ready  = !mem_busy && !mem_done;
    assign accept    = op_valid && op_ready;
    assign is_mem    = op.mem_read || op.mem_write;
    assign rd_addr_a = op.rs;   // Operands read as the op enters
    assign rd_addr_b = op.rt;
    assign opnd_b    = op.use_imm ? op.imm : rd_data_b;

    always_comb begin
        case (op.alu_op)
            ALU_SUB: alu_res = rd_data_a - opnd_b;
            ALU_AND: alu_res = rd_data_a & opnd_b;
            ALU_OR:  alu_res = rd_data_a | opnd_b;
            ALU_SLT: alu_res = {31'd0, $signed(rd_data_a) < $signed(opnd_b)};
            ALU_MUL: alu_res = rd_data_a * opnd_b;     // Low 32 bits of product
            ALU_LUI: alu_res = {opnd_b[15:0], 16'h0000};
            default: alu_res = rd_data_a + opnd_b;     // ADD, also effective address
        endcase
    end

    // STB replicates the byte, sel picks the little endian lane
    always_comb begin
        if (op.byte_store) begin
            st_sel = 4'b0001 << alu_res[1:0];
            st_dat = {4{rd_data_b[7:0]}};
        end else begin
            st_sel = 4'hf;
            st_dat = rd_data_b;
        end
    end

    // Branches and jumps redirect in their accept cycle
    assign redirect    = accept && (op.is_jump || (op.is_branch && alu_res == 32'd0));
    assign redirect_pc = op.is_jump ? op.jump_target : op.pc + 32'd4 + (op.imm << 2);

    // Load writeback takes the slot after ack, ALU results retire at once
    assign wr_en   = (mem_done && ld_wb) || (accept && op.reg_write && !op.mem_read);
    assign wr_addr = mem_done ? ld_dest : op.dest;
    assign wr_data = mem_done ? ld_data : alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_busy <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= mem_busy && bus.ack;
            if (accept && is_mem) mem_busy <= 1'b1;
            else if (bus.ack)     mem_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_mem) begin
            m_adr   <= {alu_res[31:2], 2'b00};   // Word address, lane in sel
            m_dat   <= st_dat;
            m_sel   <= op.mem_read ? 4'hf : st_sel;
            m_we    <= op.mem_write;
            ld_wb   <= op.reg_write;             // Set for LDW only
            ld_dest <= op.dest;
        end
        if (mem_busy && bus.ack) ld_data <= bus.dat_r;
    end

    assign bus.cyc   = mem_busy;
    assign bus.stb   = mem_busy;
    assign bus.we    = m_we;
    assign bus.adr   = m_adr;
    assign bus.dat_w = m_dat;
    assign bus.sel   = m_sel;

endmodule

`default_nettype wire

//--- rtl/fetch_unit.sv
`default_nettype none

module fetch_unit #(
    parameter logic [bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
    input  wire                       clk,
    input  wire                       rst_n,
    wb_if.master                      bus,
    instr_if.source                   out,
    input  wire                       redirect,
    input  wire [bus_pkg::ADDR_W-1:0] redirect_pc
);
    import bus_pkg::*;

    logic [ADDR_W-1:0] pc;          // Next fetch address
    logic [ADDR_W-1:0] fetch_adr;   // Address of the open bus cycle
    logic              busy;        // Bus cycle open
    logic              stale;       // Open cycle belongs to the old path
    logic              issue;
    logic              buf_valid;
    logic [ADDR_W-1:0] buf_pc;
    logic [DATA_W-1:0] buf_instr;

    // New fetch only with an empty buffer and an idle bus
    assign issue = !busy && !buf_valid && !redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc        <= RESET_PC;
            busy      <= 1'b0;
            stale     <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            if (busy && bus.ack) begin
                busy      <= 1'b0;    // cyc drops the cycle after ack
                stale     <= 1'b0;
                buf_valid <= !stale;  // Wrong-path data never reaches decode
            end else if (issue) begin
                busy <= 1'b1;
                pc   <= pc + 32'd4;
            end
            if (out.valid && out.ready) buf_valid <= 1'b0;
            if (redirect) begin
                // Open cycle still completes, its data dropped
                pc        <= redirect_pc;
                buf_valid <= 1'b0;
                stale     <= busy && !bus.ack;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) fetch_adr <= pc;
        if (busy && bus.ack) begin
            buf_pc    <= fetch_adr;
            buf_instr <= bus.dat_r;
        end
    end

    assign bus.cyc   = busy;
    assign bus.stb   = busy;
    assign bus.we    = 1'b0;        // Read only master
    assign bus.adr   = fetch_adr;
    assign bus.dat_w = '0;
    assign bus.sel   = '1;          // Whole word

    assign out.valid = buf_valid;
    assign out.pc    = buf_pc;
    assign out.instr = buf_instr;

endmodule

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LDW   = 6'h23;
    localparam logic [5:0] OP_STB   = 6'h28;
    localparam logic [5:0] OP_STW   = 6'h2b;

    // R-type function codes, instr[5:0]
    localparam logic [5:0] FN_MUL = 6'h18;
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_MUL, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;            // Address of this instruction
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;          // rd for R-type, rt otherwise
        logic [31:0] imm;           // Already extended
        logic [31:0] jump_target;
        alu_op_e     alu_op;
        logic        use_imm;       // ALU operand b from imm
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        byte_store;    // STB
        logic        is_branch;     // BEQ
        logic        is_jump;       // J
    } dec_op_t;

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none

module reg_file (
    input  wire        clk,
    input  wire  [4:0] rd_addr_a,
    input  wire  [4:0] rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    input  wire        wr_en,
    input  wire  [4:0] wr_addr,
    input  wire [31:0] wr_data
);

    logic [31:0] regs [32];

    // Asynchronous reads, r0 hardwired
    assign rd_data_a = (rd_addr_a == 5'd0) ? 32'd0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == 5'd0) ? 32'd0 : regs[rd_addr_b];

    always_ff @(posedge clk) begin
        if (wr_en && wr_addr != 5'd0) regs[wr_addr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- rtl/wb_arbiter.sv
`default_nettype none

module wb_arbiter (
    input  wire                       clk,
    input  wire                       rst_n,
    wb_if.slave                       data_bus,
    wb_if.slave                       fetch_bus,
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output logic [bus_pkg::ADDR_W-1:0] wb_adr,
    output logic [bus_pkg::DATA_W-1:0] wb_dat_w,
    output logic [bus_pkg::SEL_W-1:0]  wb_sel,
    input  wire [bus_pkg::DATA_W-1:0]  wb_dat_r,
    input  wire                       wb_ack
);
    import bus_pkg::*;

    logic gnt_valid;   // A master owns the port
    logic gnt;         // Owner index
    logic sel_fetch;
    logic gnt_cyc;     // Owner still in its cycle

    assign sel_fetch = (gnt == M_FETCH);
    assign gnt_cyc   = sel_fetch ? fetch_bus.cyc : data_bus.cyc;

    // Re-arbitrate when idle or once the owner drops cyc, data first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gnt_valid <= 1'b0;
            gnt       <= M_DATA;
        end else if (!gnt_valid || !gnt_cyc) begin
            gnt_valid <= data_bus.cyc || fetch_bus.cyc;
            gnt       <= data_bus.cyc ? M_DATA : M_FETCH;
        end
    end

    assign wb_cyc   = gnt_valid && gnt_cyc;
    assign wb_stb   = gnt_valid && (sel_fetch ? fetch_bus.stb : data_bus.stb);
    assign wb_we    = sel_fetch ? fetch_bus.we    : data_bus.we;
    assign wb_adr   = sel_fetch ? fetch_bus.adr   : data_bus.adr;
    assign wb_dat_w = sel_fetch ? fetch_bus.dat_w : data_bus.dat_w;
    assign wb_sel   = sel_fetch ? fetch_bus.sel   : data_bus.sel;

    // Response only to the owner
    assign data_bus.ack    = wb_ack && gnt_valid && !sel_fetch;
    assign fetch_bus.ack   = wb_ack && gnt_valid && sel_fetch;
    assign data_bus.dat_r  = sel_fetch ? '0 : wb_dat_r;
    assign fetch_bus.dat_r = sel_fetch ? wb_dat_r : '0;

endmodule

`default_nettype wire

//--- rtl/wb_if.sv
`default_nettype none

interface wb_if;
    import bus_pkg::*;

    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat_w;     // Master to slave
    logic [DATA_W-1:0] dat_r;     // Slave to master
    logic [SEL_W-1:0]  sel;
    logic              ack;       // One cycle per transfer

    modport master (output cyc, stb, we, adr, dat_w, sel, input dat_r, ack);
    modport slave  (input cyc, stb, we, adr, dat_w, sel, output dat_r, ack);
endinterface

// Fetch to decode handshake, transfer on valid and ready
interface instr_if;
    import bus_pkg::*;

    logic              valid;
    logic              ready;
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] instr;

    modport source (output valid, pc, instr, input ready);
    modport sink   (input valid, pc, instr, output ready);
endinterface

`default_nettype wire

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_cpu -f flist.f -o sim_cpu &&
./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
